//--- Bender.yml
package:
  name: dds

sources:
  - common/dds_pkg.sv
  - design/lfsr16_parallel.sv
  - design/cos_lut.sv
  - dds/phase_accumulator.sv
  - dds/dds_channel.sv
  - dds/dds_top.sv
  - target: test
    files:
      - dv/dds_clk_gen.sv
      - dv/dds_tb.sv

//--- build.f
common/dds_pkg.sv
design/lfsr16_parallel.sv
design/cos_lut.sv
dds/phase_accumulator.sv
dds/dds_channel.sv
dds/dds_top.sv
dv/dds_clk_gen.sv
dv/dds_tb.sv

//--- common/dds_pkg.sv
/*
  dds package: widths, vector types, the frequency write request and the
  cosine value function shared by the ROM and the checker
*/
package dds_pkg;

  // accumulator and quantization widths
  localparam int PHASE_BITS = 24;
  localparam int QUANT_BITS = 14;
  localparam int SAMPLE_WIDTH = 16;
  localparam int LUT_ADDR_BITS = PHASE_BITS - QUANT_BITS;
  localparam int LUT_DEPTH = 2 ** LUT_ADDR_BITS;

  // channel index field of a write, up to 16 channels
  localparam int CHAN_IDX_BITS = 4;

  // one lfsr state
  localparam int DITHER_BITS = 16;

  localparam real PI = 3.14159265358979;

  // phase or phase increment, full accumulator width
  typedef logic [PHASE_BITS-1:0] phase_t;

  // quantized phase, indexes the full-cycle table
  typedef logic [LUT_ADDR_BITS-1:0] lut_addr_t;

  // two's complement output sample
  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

  typedef logic [DITHER_BITS-1:0] dither_t;

  // one frequency write from the host, valid only
  typedef struct packed {
    logic valid;
    logic [CHAN_IDX_BITS-1:0] chan;
    phase_t inc;
  } phase_inc_req_t;

  // cos(2*pi*addr/depth) scaled just under full scale and floored
  // positive peak lands on 32767, negative peak on -32768
  function automatic sample_t cos_value(input lut_addr_t addr);
    real angle;
    real scaled;
    int floored;
    angle = 2.0 * PI * real'(addr) / real'(LUT_DEPTH);
    scaled = $cos(angle) * (2.0 ** (SAMPLE_WIDTH - 1) - 0.5);
    floored = int'($floor(scaled));
    return sample_t'(floored);
  endfunction

endpackage

//--- dds/dds_channel.sv
/*
  dds_channel: one synthesis channel, phase accumulation, optional lfsr
  phase dither, quantization to the table address and cosine lookup
*/
module dds_channel #(
  parameter int PARALLEL_SAMPLES = 4,
  parameter dds_pkg::dither_t LFSR_SEED = 16'h0001
) (
  input logic clk,
  input logic reset,
  input logic load,
  input dds_pkg::phase_t inc,
  input logic dither_en,
  output dds_pkg::sample_t [PARALLEL_SAMPLES-1:0] samples
);

  import dds_pkg::*;

  phase_t [PARALLEL_SAMPLES-1:0] sample_phase;
  dither_t [PARALLEL_SAMPLES-1:0] lfsr_states;

  // dither value per lane, zero when dithering is off
  phase_t [PARALLEL_SAMPLES-1:0] dither;

  // phase after the dither add, one register stage
  phase_t [PARALLEL_SAMPLES-1:0] phase_dithered;

  // top bits of the dithered phase
  lut_addr_t [PARALLEL_SAMPLES-1:0] lut_addr;

  phase_accumulator #(
    .PARALLEL_SAMPLES(PARALLEL_SAMPLES)
  ) phase_accumulator_inst (
    .clk,
    .reset,
    .load,
    .inc,
    .sample_phase
  );

  // runs every clock so the dither changes from word to word
  lfsr16_parallel #(
    .PARALLEL_SAMPLES(PARALLEL_SAMPLES),
    .LFSR_SEED(LFSR_SEED)
  ) lfsr16_parallel_inst (
    .clk,
    .reset,
    .enable(1'b1),
    .states(lfsr_states)
  );

  // quantization drops fewer bits than the lfsr holds
  // so only its low QUANT_BITS feed the add, always below one lsb of address
  always_comb begin
    for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
      dither[i] = dither_en ? phase_t'(lfsr_states[i][QUANT_BITS-1:0]) : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      phase_dithered <= '0;
    end else begin
      for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
        phase_dithered[i] <= sample_phase[i] + dither[i];
      end
    end
  end

  // truncating quantizer, low QUANT_BITS discarded
  always_comb begin
    for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
      lut_addr[i] = phase_dithered[i][PHASE_BITS-1:QUANT_BITS];
    end
  end

  cos_lut #(
    .PARALLEL_SAMPLES(PARALLEL_SAMPLES)
  ) cos_lut_inst (
    .clk,
    .reset,
    .addr(lut_addr),
    .data(samples)
  );

endmodule

//--- dds/dds_top.sv
/*
  dds_top: multi-channel dds, decodes host frequency writes to the channels
  and flags the sample stream valid once the pipeline has filled
*/
module dds_top #(
  parameter int PARALLEL_SAMPLES = 4,
  parameter int CHANNELS = 2
) (
  input logic clk,
  input logic reset,
  input dds_pkg::phase_inc_req_t phase_inc_req,
  input logic dither_en,
  output dds_pkg::sample_t [CHANNELS-1:0][PARALLEL_SAMPLES-1:0] samples,
  output logic valid
);

  import dds_pkg::*;

  // one load pulse per channel, at most one high per clock
  logic [CHANNELS-1:0] chan_load;

  // counts the clocks since reset release, saturates at 3
  logic [1:0] fill_count;

  for (genvar ch = 0; ch < CHANNELS; ch++) begin : gen_chan
    assign chan_load[ch] = phase_inc_req.valid
                           && (phase_inc_req.chan == CHAN_IDX_BITS'(ch));

    // distinct nonzero seed per channel so the dither is uncorrelated
    dds_channel #(
      .PARALLEL_SAMPLES(PARALLEL_SAMPLES),
      .LFSR_SEED(dither_t'(ch + 1))
    ) dds_channel_inst (
      .clk,
      .reset,
      .load(chan_load[ch]),
      .inc(phase_inc_req.inc),
      .dither_en,
      .samples(samples[ch])
    );
  end

  // accumulator, dither and lut stages fill in three clocks
  always_ff @(posedge clk) begin
    if (reset) begin
      fill_count <= '0;
    end else if (fill_count != 2'd3) begin
      fill_count <= fill_count + 2'd1;
    end
  end

  assign valid = (fill_count == 2'd3);

  // a write to a missing channel would be dropped silently
  chan_in_range_a: assert property (
    @(posedge clk) disable iff (reset)
    phase_inc_req.valid |-> int'(phase_inc_req.chan) < CHANNELS
  ) else $error("write to channel %0d, only %0d present", phase_inc_req.chan, CHANNELS);

  // real-time stream, no gaps once it has started
  valid_stays_a: assert property (
    @(posedge clk) disable iff (reset)
    valid |=> valid
  ) else $error("valid dropped outside reset");

endmodule

//--- dds/phase_accumulator.sv
/*
  phase_accumulator: holds one channel's increment multiples and the cycle
  phase, and derives the phase of each parallel sample every clock
*/
module phase_accumulator #(
  parameter int PARALLEL_SAMPLES = 4
) (
  input logic clk,
  input logic reset,
  input logic load,
  input dds_pkg::phase_t inc,
  output dds_pkg::phase_t [PARALLEL_SAMPLES-1:0] sample_phase
);

  import dds_pkg::*;

  // inc_mult[i] = (i+1)*inc, wraps modulo 2^PHASE_BITS
  // the last entry is the advance per clock
  phase_t [PARALLEL_SAMPLES-1:0] inc_mult;

  // phase of lane 0, the only value that really accumulates
  phase_t cycle_phase;

  // multiples computed once per write, not every clock
  always_ff @(posedge clk) begin
    if (reset) begin
      inc_mult <= '0;
    end else if (load) begin
      for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
        inc_mult[i] <= phase_t'(inc * (i + 1));
      end
    end
  end

  // a new increment shows up one clock after its load edge
  // the running phase carries on without a jump back to zero
  always_ff @(posedge clk) begin
    if (reset) begin
      cycle_phase <= '0;
    end else begin
      cycle_phase <= cycle_phase + inc_mult[PARALLEL_SAMPLES-1];
    end
  end

  // lane i sits i increments after the cycle phase
  // lane 0 is the earliest sample in time
  always_ff @(posedge clk) begin
    if (reset) begin
      sample_phase <= '0;
    end else begin
      sample_phase[0] <= cycle_phase;
      for (int i = 1; i < PARALLEL_SAMPLES; i++) begin
        sample_phase[i] <= cycle_phase + inc_mult[i-1];
      end
    end
  end

endmodule

//--- design/cos_lut.sv
/*
  cos_lut: full-cycle cosine rom with one registered read port per lane
*/
module cos_lut #(
  parameter int PARALLEL_SAMPLES = 4
) (
  input logic clk,
  input logic reset,
  input dds_pkg::lut_addr_t [PARALLEL_SAMPLES-1:0] addr,
  output dds_pkg::sample_t [PARALLEL_SAMPLES-1:0] data
);

  import dds_pkg::*;

  // whole period stored, wrap and dither need no quadrant folding
  sample_t rom [LUT_DEPTH];

  // table contents fixed at elaboration
  initial begin
    for (int i = 0; i < LUT_DEPTH; i++) begin
      rom[i] = cos_value(lut_addr_t'(i));
    end
  end

  // one read per lane, all lanes in the same cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      data <= '0;
    end else begin
      for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
        data[i] <= rom[addr[i]];
      end
    end
  end

endmodule

//--- design/lfsr16_parallel.sv
/*
  lfsr16_parallel: maximal 16-bit fibonacci lfsr, x^16+x^15+x^13+x^4+1,
  advanced several steps per clock with every intermediate state exposed
*/
module lfsr16_parallel #(
  parameter int PARALLEL_SAMPLES = 4,
  parameter dds_pkg::dither_t LFSR_SEED = 16'h0001
) (
  input logic clk,
  input logic reset,
  input logic enable,
  output dds_pkg::dither_t [PARALLEL_SAMPLES-1:0] states
);

  import dds_pkg::*;

  // unrolled chain of single steps for the next clock
  dither_t [PARALLEL_SAMPLES-1:0] next_states;

  // one shift of the register
  // taps 16, 15, 13 and 4 map to bits 15, 14, 12 and 3
  function automatic dither_t lfsr_step(input dither_t s);
    logic feedback;
    feedback = s[15] ^ s[14] ^ s[12] ^ s[3];
    return {s[14:0], feedback};
  endfunction

  // lane 0 continues from the last lane of the previous clock
  always_comb begin
    next_states[0] = lfsr_step(states[PARALLEL_SAMPLES-1]);
    for (int i = 1; i < PARALLEL_SAMPLES; i++) begin
      next_states[i] = lfsr_step(next_states[i-1]);
    end
  end

  // every lane starts at the seed
  // the chain separates them from the first enabled clock on
  always_ff @(posedge clk) begin
    if (reset) begin
      states <= {PARALLEL_SAMPLES{LFSR_SEED}};
    end else if (enable) begin
      states <= next_states;
    end
  end

  // a zero state would lock the sequence up for good
  lfsr_nonzero_a: assert property (
    @(posedge clk) disable iff (reset)
    enable |=> states[PARALLEL_SAMPLES-1] != '0
  ) else $error("lfsr reached the all-zero lock-up state");

endmodule

//--- dv/dds_clk_gen.sv
/*
  dds_clk_gen: free-running testbench clock
*/
module dds_clk_gen #(
  parameter real PERIOD_NS = 10.0
) (
  output logic clk
);

  timeunit 1ns;
  timeprecision 1ps;

  // starts low, first rising edge half a period in
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) clk = ~clk;
    end
  end

endmodule

//--- dv/dds_tb.sv
/*
  dds_tb: table-driven testbench for dds_top with a cycle model of the
  accumulators, two-stage output alignment and a watchdog
*/
module dds_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import dds_pkg::*;

  localparam int LANES = 4;
  localparam int CHANNELS = 2;
  localparam int NUM_ROWS = 10;
  localparam int RESET_CYCLES = 8;
  localparam int CLK_PERIOD_NS = 10;
  localparam int WATCHDOG_MARGIN = 100;

  logic clk;
  logic reset;
  phase_inc_req_t phase_inc_req;
  logic dither_en;
  sample_t [CHANNELS-1:0][LANES-1:0] samples;
  logic valid;

  // stimulus table, one entry per test row
  string row_name [NUM_ROWS] = '{"reset_idle", "tone_ch0", "tone_ch1", "retune_ch0",
                                 "dither_ch0", "dither_ch1", "rand_plain_ch0",
                                 "rand_dither_ch1", "rand_plain_ch1", "rand_dither_ch0"};
  int row_chan [NUM_ROWS] = '{0, 0, 1, 0, 0, 1, 0, 1, 1, 0};
  phase_t row_inc [NUM_ROWS] = '{24'h000000, 24'h012345, 24'h0a0000, 24'h3fc001,
                                 24'h001357, 24'h0f0f0f, 24'h000000, 24'h000000,
                                 24'h000000, 24'h000000};
  // row takes its increment from the xorshift generator
  bit row_rand [NUM_ROWS] = '{0, 0, 0, 0, 0, 0, 1, 1, 1, 1};
  bit row_write [NUM_ROWS] = '{0, 1, 1, 1, 1, 1, 1, 1, 1, 1};
  bit row_dither [NUM_ROWS] = '{0, 0, 0, 0, 1, 1, 0, 1, 0, 1};
  int row_cycles [NUM_ROWS] = '{12, 40, 40, 40, 48, 48, 40, 40, 32, 32};

  // model state, one variable per design register
  phase_t m_mult [CHANNELS][LANES];
  phase_t m_cycle [CHANNELS];
  phase_t m_phase [CHANNELS][LANES];
  // address pipeline, s2 lines up with the lut output
  lut_addr_t s1_addr [CHANNELS][LANES];
  lut_addr_t s2_addr [CHANNELS][LANES];
  bit s1_dith;
  bit s2_dith;
  bit in_reset;
  int edges_since_reset;

  string cur_name;
  int cur_chan;
  int diff_count;
  logic [31:0] rng_state = 32'd21;

  dds_clk_gen #(
    .PERIOD_NS(CLK_PERIOD_NS)
  ) dds_clk_gen_inst (
    .clk
  );

  dds_top #(
    .PARALLEL_SAMPLES(LANES),
    .CHANNELS(CHANNELS)
  ) dds_top_inst (
    .clk,
    .reset,
    .phase_inc_req,
    .dither_en,
    .samples,
    .valid
  );

  // 32-bit xorshift, shifts 13, 17, 5
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // four-state compare, an unknown output never matches
  task automatic check_value(input string name,
                             input logic signed [63:0] expected,
                             input logic signed [63:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
      $display("Testbench failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // one rising edge of the model, inputs are the values driven before it
  task automatic advance_model();
    in_reset = reset;
    if (reset) begin
      for (int ch = 0; ch < CHANNELS; ch++) begin
        m_cycle[ch] = '0;
        for (int i = 0; i < LANES; i++) begin
          m_mult[ch][i] = '0;
          m_phase[ch][i] = '0;
          s1_addr[ch][i] = '0;
          s2_addr[ch][i] = '0;
        end
      end
      s1_dith = 1'b0;
      s2_dith = 1'b0;
      edges_since_reset = 0;
    end else begin
      // later stages first so each one reads the old value
      s2_addr = s1_addr;
      s2_dith = s1_dith;
      s1_dith = dither_en;
      for (int ch = 0; ch < CHANNELS; ch++) begin
        for (int i = 0; i < LANES; i++) begin
          s1_addr[ch][i] = m_phase[ch][i][PHASE_BITS-1:QUANT_BITS];
        end
        m_phase[ch][0] = m_cycle[ch];
        for (int i = 1; i < LANES; i++) begin
          m_phase[ch][i] = m_cycle[ch] + m_mult[ch][i-1];
        end
        m_cycle[ch] = m_cycle[ch] + m_mult[ch][LANES-1];
        // new multiples land at the write edge itself
        if (phase_inc_req.valid && int'(phase_inc_req.chan) == ch) begin
          for (int i = 0; i < LANES; i++) begin
            m_mult[ch][i] = phase_t'(phase_inc_req.inc * (i + 1));
          end
        end
      end
      if (edges_since_reset < 3) begin
        edges_since_reset++;
      end
    end
  endtask

  // outputs are sampled at the falling edge, half a period after they change
  task automatic check_outputs();
    longint expected;
    sample_t actual;
    sample_t base;
    sample_t alt;
    lut_addr_t next_addr;
    check_value($sformatf("%s valid", cur_name), longint'(edges_since_reset >= 3), valid);
    for (int ch = 0; ch < CHANNELS; ch++) begin
      for (int i = 0; i < LANES; i++) begin
        actual = samples[ch][i];
        next_addr = s2_addr[ch][i] + 1'b1;
        base = cos_value(s2_addr[ch][i]);
        alt = cos_value(next_addr);
        if (in_reset) begin
          expected = 0;
        end else if (s2_dith) begin
          // dither below one address step moves the lookup by at most one
          expected = (actual == alt) ? alt : base;
          if (ch == cur_chan && actual != base) begin
            diff_count++;
          end
        end else begin
          expected = base;
        end
        check_value($sformatf("%s ch%0d lane%0d", cur_name, ch, i), expected, actual);
      end
    end
  endtask

  task automatic run_cycle();
    @(posedge clk);
    advance_model();
    @(negedge clk);
    check_outputs();
  endtask

  initial begin : watchdog
    int total;
    total = RESET_CYCLES + WATCHDOG_MARGIN;
    for (int r = 0; r < NUM_ROWS; r++) begin
      total += row_cycles[r];
    end
    #(total * CLK_PERIOD_NS);
    $display("watchdog fired, run timed out after %0d cycles", total);
    $display("Testbench failed");
    $fatal(1, "timeout");
  end

  initial begin : stimulus
    phase_t inc;
    reset = 1'b1;
    phase_inc_req = '0;
    dither_en = 1'b0;
    cur_name = "reset";
    cur_chan = 0;
    diff_count = 0;
    repeat (RESET_CYCLES) run_cycle();
    // release on a falling edge
    reset = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (row_rand[r]) begin
        rng_state = xorshift32(rng_state);
        inc = rng_state[PHASE_BITS-1:0];
      end else begin
        inc = row_inc[r];
      end
      cur_name = row_name[r];
      cur_chan = row_chan[r];
      diff_count = 0;
      dither_en = row_dither[r];
      if (row_write[r]) begin
        phase_inc_req.valid = 1'b1;
        phase_inc_req.chan = CHAN_IDX_BITS'(row_chan[r]);
        phase_inc_req.inc = inc;
      end
      for (int c = 0; c < row_cycles[r]; c++) begin
        run_cycle();
        // single-cycle write
        phase_inc_req.valid = 1'b0;
      end
      // a fractional increment with dither on must move some lookups
      if (row_dither[r] && inc[QUANT_BITS-1:0] != '0) begin
        check_value($sformatf("%s dither activity", cur_name), 1, longint'(diff_count != 0));
      end
    end
    $display("Testbench passed");
    $finish;
  end

endmodule
